// File: common/mul_types_pkg.sv
// Operator, MULH step and sign-mode encodings for the shared multiply unit
// Used by the request interface, the ingress ports and the multiplier core
package mul_types_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Operator
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [0:0] {
    MUL_M32 = 1'b0,  // Low 32 bits, single step
    MUL_H   = 1'b1   // High 32 bits, 4-step sequence
  } mul_opcode_e;

  ////////////////////////////////////////////////////////////////////////////
  // MULH sequence steps
  ////////////////////////////////////////////////////////////////////////////

  // One 17x17 partial product per step
  typedef enum logic [1:0] {
    MUL_ALBL = 2'b00,  // al * bl
    MUL_ALBH = 2'b01,  // al * bh
    MUL_AHBL = 2'b10,  // ah * bl
    MUL_AHBH = 2'b11   // ah * bh, result issued
  } mul_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Sign mode
  ////////////////////////////////////////////////////////////////////////////

  // Bit 0 marks operand a signed, bit 1 operand b signed
  typedef enum logic [1:0] {
    SIGN_UU = 2'b00,  // MULHU
    SIGN_SU = 2'b01,  // MULHSU
    SIGN_SS = 2'b11   // MULH
  } mul_sign_e;

endpackage

// File: common/mul_cfg_pkg.sv
// Sizes of the shared multiply unit
// Data width and requester numbering for ports, arbiter and core
package mul_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  localparam int DATA_W = 32;  // Operand and result width

  ////////////////////////////////////////////////////////////////////////////
  // Requesters
  ////////////////////////////////////////////////////////////////////////////

  localparam int NUM_REQ = 2;  // Fixed, two issue slots

  // Id tag carried with each request back to the response decode
  localparam int ID_W = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

endpackage

// File: common/mul_req_if.sv
`timescale 1ns/1ns
// Valid/ready request channel of the multiply unit
// Links each ingress port to the arbiter and the arbiter to the core
interface mul_req_if;
  import mul_types_pkg::*;
  import mul_cfg_pkg::*;

  logic              valid;  // Held until the transfer
  logic              ready;  // Driven by the sink
  mul_opcode_e       op;
  mul_sign_e         sign;   // MULH flavour
  logic [DATA_W-1:0] op_a;
  logic [DATA_W-1:0] op_b;
  logic [ID_W-1:0]   id;     // Requester that owns the entry

  // Request side
  modport source (
    output valid,
    output op,
    output sign,
    output op_a,
    output op_b,
    output id,
    input  ready
  );

  // Accepting side
  modport sink (
    input  valid,
    input  op,
    input  sign,
    input  op_a,
    input  op_b,
    input  id,
    output ready
  );

endinterface

// File: source/mul_ingress_port.sv
`timescale 1ns/1ns
// Request FIFO for one requester, sized by the credits the sender owns
// Every popped entry returns one credit through a single-cycle pulse
module mul_ingress_port #(
  parameter int CREDITS = 4,  // FIFO depth, equal to the sender's credits
  parameter int ID      = 0   // Requester number stamped on each entry
) (
  input  logic                           clk,
  input  logic                           arst_n_i,
  input  logic                           req_valid_i,  // Spends one credit
  input  mul_types_pkg::mul_opcode_e     req_op_i,
  input  mul_types_pkg::mul_sign_e       req_sign_i,
  input  logic [mul_cfg_pkg::DATA_W-1:0] req_a_i,
  input  logic [mul_cfg_pkg::DATA_W-1:0] req_b_i,
  output logic                           credit_o,     // Returns one credit
  mul_req_if.source                      out
);
  import mul_types_pkg::*;
  import mul_cfg_pkg::*;

  localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
  localparam int CNT_W = $clog2(CREDITS + 1);
  localparam logic [ID_W-1:0] PORT_ID = ID_W'(ID);

  // Entry storage
  mul_opcode_e       op_mem   [CREDITS];
  mul_sign_e         sign_mem [CREDITS];
  logic [DATA_W-1:0] a_mem    [CREDITS];
  logic [DATA_W-1:0] b_mem    [CREDITS];

  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;   // Occupancy
  logic              pop;

  // Wrap at CREDITS, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(CREDITS - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (req_valid_i) begin  // Never full while the sender holds a credit
      op_mem[wr_ptr_q]   <= req_op_i;
      sign_mem[wr_ptr_q] <= req_sign_i;
      a_mem[wr_ptr_q]    <= req_a_i;
      b_mem[wr_ptr_q]    <= req_b_i;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end else begin
      if (req_valid_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({req_valid_i, pop})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;  // Idle or push and pop together
      endcase
      credit_o <= pop;  // Credit goes back the cycle after the pop
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Head entry on the interface
  ////////////////////////////////////////////////////////////////////////////

  assign out.valid = (count_q != '0);
  assign out.op    = op_mem[rd_ptr_q];
  assign out.sign  = sign_mem[rd_ptr_q];
  assign out.op_a  = a_mem[rd_ptr_q];
  assign out.op_b  = b_mem[rd_ptr_q];
  assign out.id    = PORT_ID;
  assign pop       = out.valid && out.ready;  // Head leaves for the core

endmodule

// File: source/mul_arbiter.sv
`timescale 1ns/1ns
// Round-robin merge of the two ingress ports onto the core request channel
// Grant is combinational, the priority pointer moves on each transfer
module mul_arbiter (
  input  logic      clk,
  input  logic      arst_n_i,
  mul_req_if.sink   in0,
  mul_req_if.sink   in1,
  mul_req_if.source out
);

  logic prio_q;  // Input that wins when both are valid
  logic sel;     // Current winner

  // Pick the winner
  always_comb begin
    if (in0.valid && in1.valid) begin
      sel = prio_q;
    end else begin
      sel = in1.valid;  // Only one or none valid
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Payload mux and ready routing
  ////////////////////////////////////////////////////////////////////////////

  assign out.valid = in0.valid || in1.valid;
  assign out.op    = sel ? in1.op   : in0.op;
  assign out.sign  = sel ? in1.sign : in0.sign;
  assign out.op_a  = sel ? in1.op_a : in0.op_a;
  assign out.op_b  = sel ? in1.op_b : in0.op_b;
  assign out.id    = sel ? in1.id   : in0.id;

  assign in0.ready = out.ready && !sel;  // Loser sees ready low
  assign in1.ready = out.ready && sel;

  // Other input gets priority after a transfer
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prio_q <= 1'b0;
    end else if (out.valid && out.ready) begin
      prio_q <= !sel;
    end
  end

endmodule

// File: mult/mult_core.sv
`timescale 1ns/1ns
// Iterative integer multiplier shared by both requesters
// MUL answers in one step, MULH runs four 17x17 partial products
module mult_core (
  input  logic                           clk,
  input  logic                           arst_n_i,
  mul_req_if.sink                        req,
  output logic                           res_valid_o,
  output logic [mul_cfg_pkg::ID_W-1:0]   res_id_o,     // Owner of the result
  output logic [mul_cfg_pkg::DATA_W-1:0] res_result_o
);
  import mul_types_pkg::*;
  import mul_cfg_pkg::*;

  localparam int HALF_W = DATA_W / 2;  // 16
  localparam int PART_W = HALF_W + 1;  // Half plus sign bit
  localparam int PROD_W = 2 * PART_W;  // Partial product and accumulator

  // Control
  logic                     busy_q;       // MULH sequence running
  mul_state_e               state_q;
  logic                     m32_valid_q;  // MUL result this cycle
  logic                     accept;

  // Payload
  logic [DATA_W-1:0]        m32_res_q;
  logic [DATA_W-1:0]        m32_prod;
  logic [ID_W-1:0]          id_q;
  logic [DATA_W-1:0]        a_q;
  logic [DATA_W-1:0]        b_q;
  mul_sign_e                sign_q;
  logic signed [PROD_W-1:0] acc_q;

  // MULH datapath
  logic                     a_signed;
  logic                     b_signed;
  logic [PART_W-1:0]        al;
  logic [PART_W-1:0]        ah;
  logic [PART_W-1:0]        bl;
  logic [PART_W-1:0]        bh;
  logic [PART_W-1:0]        mul_a;
  logic [PART_W-1:0]        mul_b;
  logic signed [PROD_W-1:0] pp;           // Partial product of this step
  logic signed [PROD_W-1:0] acc_sum;

  assign req.ready = !busy_q;  // Idle means ready
  assign accept    = req.valid && !busy_q;

  // Low half is the same for signed and unsigned operands
  assign m32_prod = $signed(req.op_a) * $signed(req.op_b);

  ////////////////////////////////////////////////////////////////////////////
  // Operand split and partial product
  ////////////////////////////////////////////////////////////////////////////

  assign a_signed = (sign_q == SIGN_SU) || (sign_q == SIGN_SS);
  assign b_signed = (sign_q == SIGN_SS);

  // Low halves are always unsigned, high halves carry the sign
  assign al = {1'b0, a_q[HALF_W-1:0]};
  assign ah = {a_signed & a_q[DATA_W-1], a_q[DATA_W-1:HALF_W]};
  assign bl = {1'b0, b_q[HALF_W-1:0]};
  assign bh = {b_signed & b_q[DATA_W-1], b_q[DATA_W-1:HALF_W]};

  always_comb begin
    case (state_q)
      MUL_ALBL: begin
        mul_a = al;
        mul_b = bl;
      end
      MUL_ALBH: begin
        mul_a = al;
        mul_b = bh;
      end
      MUL_AHBL: begin
        mul_a = ah;
        mul_b = bl;
      end
      default: begin  // MUL_AHBH
        mul_a = ah;
        mul_b = bh;
      end
    endcase
  end

  // One 17x17 multiplier
  assign pp      = PROD_W'($signed(mul_a)) * PROD_W'($signed(mul_b));
  assign acc_sum = acc_q + pp;

  ////////////////////////////////////////////////////////////////////////////
  // Sequence control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q      <= 1'b0;
      state_q     <= MUL_ALBL;
      m32_valid_q <= 1'b0;
    end else begin
      m32_valid_q <= accept && (req.op == MUL_M32);
      if (accept && (req.op == MUL_H)) begin
        busy_q  <= 1'b1;
        state_q <= MUL_ALBL;
      end else if (busy_q) begin
        case (state_q)
          MUL_ALBL: state_q <= MUL_ALBH;
          MUL_ALBH: state_q <= MUL_AHBL;
          MUL_AHBL: state_q <= MUL_AHBH;
          default: begin  // Result leaves in AHBH
            busy_q  <= 1'b0;
            state_q <= MUL_ALBL;
          end
        endcase
      end
    end
  end

  // Operand latch and accumulator
  always_ff @(posedge clk) begin
    if (accept) begin
      id_q      <= req.id;
      a_q       <= req.op_a;
      b_q       <= req.op_b;
      sign_q    <= req.sign;
      m32_res_q <= m32_prod;
      acc_q     <= '0;  // Fresh sequence
    end else if (busy_q) begin
      case (state_q)
        MUL_ALBL: acc_q <= acc_sum >>> HALF_W;  // Keep carry of al*bl only
        MUL_ALBH: acc_q <= acc_sum;
        MUL_AHBL: acc_q <= acc_sum >>> HALF_W;  // Align to ah*bh weight
        default:  acc_q <= acc_q;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result
  ////////////////////////////////////////////////////////////////////////////

  // MULH result is the final sum, issued in AHBH
  assign res_valid_o  = m32_valid_q || (busy_q && (state_q == MUL_AHBH));
  assign res_result_o = busy_q ? acc_sum[DATA_W-1:0] : m32_res_q;
  assign res_id_o     = id_q;

endmodule

// File: source/mult_sub.sv
`timescale 1ns/1ns
// Shared multiply unit for two requesters with credit flow control
// Top level of the subsystem, responses routed back by requester id
module mult_sub #(
  parameter int CREDITS = 4  // Credits per requester and ingress depth
) (
  input  logic                           clk,
  input  logic                           arst_n_i,
  // Requester 0
  input  logic                           req0_valid_i,
  input  mul_types_pkg::mul_opcode_e     req0_op_i,
  input  mul_types_pkg::mul_sign_e       req0_sign_i,
  input  logic [mul_cfg_pkg::DATA_W-1:0] req0_a_i,
  input  logic [mul_cfg_pkg::DATA_W-1:0] req0_b_i,
  output logic                           credit0_o,
  output logic                           rsp0_valid_o,
  output logic [mul_cfg_pkg::DATA_W-1:0] rsp0_result_o,
  // Requester 1
  input  logic                           req1_valid_i,
  input  mul_types_pkg::mul_opcode_e     req1_op_i,
  input  mul_types_pkg::mul_sign_e       req1_sign_i,
  input  logic [mul_cfg_pkg::DATA_W-1:0] req1_a_i,
  input  logic [mul_cfg_pkg::DATA_W-1:0] req1_b_i,
  output logic                           credit1_o,
  output logic                           rsp1_valid_o,
  output logic [mul_cfg_pkg::DATA_W-1:0] rsp1_result_o
);
  import mul_cfg_pkg::*;

  logic              res_valid;
  logic [ID_W-1:0]   res_id;
  logic [DATA_W-1:0] res_result;

  mul_req_if port0_if ();  // Port 0 to arbiter
  mul_req_if port1_if ();  // Port 1 to arbiter
  mul_req_if core_if ();   // Arbiter to core

  ////////////////////////////////////////////////////////////////////////////
  // Ingress, arbitration, multiplier
  ////////////////////////////////////////////////////////////////////////////

  mul_ingress_port #(.CREDITS(CREDITS), .ID(0)) port0_inst (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .req_valid_i(req0_valid_i),
    .req_op_i   (req0_op_i),
    .req_sign_i (req0_sign_i),
    .req_a_i    (req0_a_i),
    .req_b_i    (req0_b_i),
    .credit_o   (credit0_o),
    .out        (port0_if)
  );

  // Last requester
  mul_ingress_port #(.CREDITS(CREDITS), .ID(NUM_REQ - 1)) port1_inst (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .req_valid_i(req1_valid_i),
    .req_op_i   (req1_op_i),
    .req_sign_i (req1_sign_i),
    .req_a_i    (req1_a_i),
    .req_b_i    (req1_b_i),
    .credit_o   (credit1_o),
    .out        (port1_if)
  );

  mul_arbiter arbiter_inst (
    .clk     (clk),
    .arst_n_i(arst_n_i),
    .in0     (port0_if),
    .in1     (port1_if),
    .out     (core_if)
  );

  mult_core core_inst (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req         (core_if),
    .res_valid_o (res_valid),
    .res_id_o    (res_id),
    .res_result_o(res_result)
  );

  // Response routing by id, result bus shared
  assign rsp0_valid_o  = res_valid && (res_id == ID_W'(0));
  assign rsp1_valid_o  = res_valid && (res_id == ID_W'(NUM_REQ - 1));
  assign rsp0_result_o = res_result;
  assign rsp1_result_o = res_result;

endmodule

// File: test/mult_sub_props.sv
`timescale 1ns/1ns
// Result, ordering, credit and reset checks for the multiply unit, bound into mult_sub
// Holds the expected result of every pending request of each requester
module mult_sub_props #(
  parameter int CREDITS = 4  // Same depth as the ingress ports
) (
  input logic                           clk,
  input logic                           arst_n_i,
  input logic                           req0_valid_i,
  input mul_types_pkg::mul_opcode_e     req0_op_i,
  input mul_types_pkg::mul_sign_e       req0_sign_i,
  input logic [mul_cfg_pkg::DATA_W-1:0] req0_a_i,
  input logic [mul_cfg_pkg::DATA_W-1:0] req0_b_i,
  input logic                           credit0_o,
  input logic                           rsp0_valid_o,
  input logic [mul_cfg_pkg::DATA_W-1:0] rsp0_result_o,
  input logic                           req1_valid_i,
  input mul_types_pkg::mul_opcode_e     req1_op_i,
  input mul_types_pkg::mul_sign_e       req1_sign_i,
  input logic [mul_cfg_pkg::DATA_W-1:0] req1_a_i,
  input logic [mul_cfg_pkg::DATA_W-1:0] req1_b_i,
  input logic                           credit1_o,
  input logic                           rsp1_valid_o,
  input logic [mul_cfg_pkg::DATA_W-1:0] rsp1_result_o
);
  import mul_types_pkg::*;
  import mul_cfg_pkg::*;

  localparam int RING_W   = $clog2(CREDITS + 2);  // FIFO entries plus one in the core
  localparam int MAX_SKIP = 2;  // Other-requester responses while one waits

  int unsigned fail_cnt = 0;  // Failed checks, read at the end of the run

  // Both requesters side by side
  logic              req_v    [2];
  mul_opcode_e       req_op   [2];
  mul_sign_e         req_sign [2];
  logic [DATA_W-1:0] req_a    [2];
  logic [DATA_W-1:0] req_b    [2];
  logic              credit   [2];
  logic              rsp_v    [2];
  logic [DATA_W-1:0] rsp_res  [2];

  assign req_v    = '{req0_valid_i, req1_valid_i};
  assign req_op   = '{req0_op_i, req1_op_i};
  assign req_sign = '{req0_sign_i, req1_sign_i};
  assign req_a    = '{req0_a_i, req1_a_i};
  assign req_b    = '{req0_b_i, req1_b_i};
  assign credit   = '{credit0_o, credit1_o};
  assign rsp_v    = '{rsp0_valid_o, rsp1_valid_o};
  assign rsp_res  = '{rsp0_result_o, rsp1_result_o};

  // Full 64-bit product, operands extended as the sign mode says
  function automatic logic [DATA_W-1:0] ref_result(input mul_opcode_e op,
                                                   input mul_sign_e   sign,
                                                   input logic [DATA_W-1:0] a,
                                                   input logic [DATA_W-1:0] b);
    logic [2*DATA_W-1:0] xa;
    logic [2*DATA_W-1:0] xb;
    logic [2*DATA_W-1:0] prod;
    xa   = (op == MUL_M32 || sign != SIGN_UU) ? {{DATA_W{a[DATA_W-1]}}, a} : {{DATA_W{1'b0}}, a};
    xb   = (op == MUL_M32 || sign == SIGN_SS) ? {{DATA_W{b[DATA_W-1]}}, b} : {{DATA_W{1'b0}}, b};
    prod = xa * xb;  // Wraps mod 2**64, exact for every mode
    return (op == MUL_M32) ? prod[DATA_W-1:0] : prod[2*DATA_W-1:DATA_W];
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // Reset values
  //////////////////////////////////////////////////////////////////////////

  reset_quiet_a: assert property (@(posedge clk)
    (!arst_n_i || !$past(arst_n_i)) |->
      !(credit0_o || credit1_o || rsp0_valid_o || rsp1_valid_o))
  else begin
    $error("Credit or response output active in reset or the cycle after it");
    fail_cnt++;
  end

  //////////////////////////////////////////////////////////////////////////
  // Per requester reference queue
  //////////////////////////////////////////////////////////////////////////

  for (genvar n = 0; n < 2; n++) begin : g_req
    logic [DATA_W-1:0] exp_mem [2**RING_W];  // Expected results in request order
    logic [RING_W-1:0] wr_q;
    logic [RING_W-1:0] rd_q;
    logic [DATA_W-1:0] exp_head;
    logic              pending;
    int                used_q;  // Credits held by the ingress port
    int                skip_q;  // Other responses since the last own one

    assign exp_head = exp_mem[rd_q];
    assign pending  = (wr_q != rd_q);

    always_ff @(posedge clk) begin
      if (req_v[n]) begin
        exp_mem[wr_q] <= ref_result(req_op[n], req_sign[n], req_a[n], req_b[n]);
      end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
        wr_q   <= '0;
        rd_q   <= '0;
        used_q <= 0;
        skip_q <= 0;
      end else begin
        if (req_v[n]) begin
          wr_q <= wr_q + RING_W'(1);
        end
        if (rsp_v[n]) begin
          rd_q <= rd_q + RING_W'(1);
        end
        used_q <= used_q + int'(req_v[n]) - int'(credit[n]);
        if (rsp_v[n] || !pending) begin
          skip_q <= 0;
        end else if (rsp_v[1-n]) begin
          skip_q <= skip_q + 1;  // Still waiting while the other side is served
        end
      end
    end

    order_a: assert property (@(posedge clk) disable iff (!arst_n_i)
      rsp_v[n] |-> pending)
    else begin
      $error("Response on requester %0d with no request pending", n);
      fail_cnt++;
    end

    result_a: assert property (@(posedge clk) disable iff (!arst_n_i)
      (rsp_v[n] && pending) |-> (rsp_res[n] == exp_head))
    else begin
      $error("ERROR result%0d: expected %h actual %h", n, $sampled(exp_head),
             $sampled(rsp_res[n]));
      fail_cnt++;
    end

    credit_a: assert property (@(posedge clk) disable iff (!arst_n_i)
      (used_q >= 0) && (used_q <= CREDITS))
    else begin
      $error("ERROR credits%0d: expected 0 to %0d actual %0d", n, CREDITS,
             $sampled(used_q));
      fail_cnt++;
    end

    fair_a: assert property (@(posedge clk) disable iff (!arst_n_i)
      skip_q <= MAX_SKIP)
    else begin
      $error("Requester %0d starved by the other requester", n);
      fail_cnt++;
    end
  end

endmodule

// File: test/mult_sub_tb.sv
`timescale 1ns/1ns
// Testbench for the shared multiply unit with random traffic on both requesters
// Senders respect their credits, results are checked by the bound props module
module mult_sub_tb;
  import mul_types_pkg::*;
  import mul_cfg_pkg::*;

  localparam int CREDITS = 4;
  localparam int NUM_OPS = 64;               // Requests per requester
  localparam int TIMEOUT = NUM_OPS * 6 * 2;  // Cycles, both requesters at a slow pace

  logic              clk;
  logic              arst_n_i;
  logic              req_v    [2];
  mul_opcode_e       req_op   [2];
  mul_sign_e         req_sign [2];
  logic [DATA_W-1:0] req_a    [2];
  logic [DATA_W-1:0] req_b    [2];
  logic              credit   [2];
  logic              rsp_v    [2];
  logic [DATA_W-1:0] rsp_res  [2];

  logic [31:0] seed = 32'hd98a;  // Random state
  int          credits [2];     // Credits held by each sender
  int          sent    [2];
  int          recv    [2];
  int          cycles;
  int          errors;

  mult_sub #(.CREDITS(CREDITS)) mult_sub_inst (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .req0_valid_i (req_v[0]),
    .req0_op_i    (req_op[0]),
    .req0_sign_i  (req_sign[0]),
    .req0_a_i     (req_a[0]),
    .req0_b_i     (req_b[0]),
    .credit0_o    (credit[0]),
    .rsp0_valid_o (rsp_v[0]),
    .rsp0_result_o(rsp_res[0]),
    .req1_valid_i (req_v[1]),
    .req1_op_i    (req_op[1]),
    .req1_sign_i  (req_sign[1]),
    .req1_a_i     (req_a[1]),
    .req1_b_i     (req_b[1]),
    .credit1_o    (credit[1]),
    .rsp1_valid_o (rsp_v[1]),
    .rsp1_result_o(rsp_res[1])
  );

  bind mult_sub mult_sub_props #(.CREDITS(CREDITS)) props_inst (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Corner values 0, -1 and 0x80000000 in three of eight draws
  function automatic logic [31:0] pick_operand(input logic [2:0] sel, input logic [31:0] val);
    case (sel)
      3'd0:    return 32'h0000_0000;
      3'd1:    return 32'hffff_ffff;
      3'd2:    return 32'h8000_0000;
      default: return val;
    endcase
  endfunction

  function automatic mul_sign_e pick_sign(input logic [1:0] sel);
    case (sel)
      2'd0:    return SIGN_UU;
      2'd1:    return SIGN_SU;
      default: return SIGN_SS;
    endcase
  endfunction

  // One request on requester n, spends a credit
  task automatic send_request(input int n);
    logic [31:0] r;
    seed = xorshift(seed);
    r    = seed;
    req_op[n]   = r[0] ? MUL_H : MUL_M32;
    req_sign[n] = pick_sign(r[2:1]);
    seed        = xorshift(seed);
    req_a[n]    = pick_operand(r[5:3], seed);
    seed        = xorshift(seed);
    req_b[n]    = pick_operand(r[8:6], seed);
    req_v[n]    = 1'b1;
    credits[n]--;
    sent[n]++;
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus, counting and the closing report
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    arst_n_i = 1'b0;
    cycles   = 0;
    errors   = 0;
    for (int n = 0; n < 2; n++) begin
      req_v[n]    = 1'b0;
      req_op[n]   = MUL_M32;
      req_sign[n] = SIGN_UU;
      req_a[n]    = '0;
      req_b[n]    = '0;
      credits[n]  = CREDITS;  // Full credit after reset
      sent[n]     = 0;
      recv[n]     = 0;
    end
    repeat (2) @(posedge clk);  // Reset held for two cycles
    @(negedge clk);
    arst_n_i = 1'b1;

    while ((sent[0] < NUM_OPS || sent[1] < NUM_OPS || recv[0] < sent[0] ||
            recv[1] < sent[1] || credits[0] < CREDITS || credits[1] < CREDITS) &&
           cycles < TIMEOUT) begin
      @(negedge clk);  // Outputs stable, inputs change here
      cycles++;
      for (int n = 0; n < 2; n++) begin
        if (credit[n]) begin
          credits[n]++;
        end
        if (rsp_v[n]) begin
          recv[n]++;
        end
        req_v[n] = 1'b0;
        seed     = xorshift(seed);
        if (sent[n] < NUM_OPS && credits[n] > 0 && seed[1:0] != 2'b00) begin
          send_request(n);  // Idle one cycle in four
        end
      end
    end
    repeat (2) @(negedge clk);  // Bound checks see the last response

    if (cycles >= TIMEOUT) begin
      $display("Timeout after %0d cycles with requests or responses outstanding", cycles);
      errors++;
    end
    for (int n = 0; n < 2; n++) begin
      assert (recv[n] == NUM_OPS) else begin
        $display("ERROR rsp_count%0d: expected %0d actual %0d", n, NUM_OPS, recv[n]);
        errors++;
      end
      assert (credits[n] == CREDITS) else begin
        $display("ERROR credit_return%0d: expected %0d actual %0d", n, CREDITS, credits[n]);
        errors++;
      end
    end

    $display("Errors: %0d testbench, %0d assertion", errors,
             mult_sub_inst.props_inst.fail_cnt);
    if (errors == 0 && mult_sub_inst.props_inst.fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: mult_sub.f
common/mul_types_pkg.sv
common/mul_cfg_pkg.sv
common/mul_req_if.sv
source/mul_ingress_port.sv
source/mul_arbiter.sv
mult/mult_core.sv
source/mult_sub.sv
test/mult_sub_props.sv
test/mult_sub_tb.sv

// File: Makefile
# Verilator build and run of the multiply unit testbench

VERILATOR ?= verilator
TOP       ?= mult_sub_tb
FILELIST  ?= mult_sub.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= all tests passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
